// File: dcache_axi_params.svh
`ifndef DCACHE_AXI_PARAMS_SVH
`define DCACHE_AXI_PARAMS_SVH

// bus widths
`define ADDR_WIDTH 32
`define AXI_DATA_WIDTH 32
`define AXI_ID_WIDTH 4

// slave word array, only the low word-address bits index it
`define MEM_WORDS 256

// cycles from accepting a request to its response
`define MEM_LATENCY 3

// longest run of ready low before the master counts as stuck
`define STUCK_LIMIT 3000

`endif

// File: dcache_axi_pkg.sv
`include "dcache_axi_params.svh"

package dcache_axi_pkg;

    // byte address
    typedef logic [`ADDR_WIDTH-1:0] addr_t;

    // one bus word and its byte enables
    typedef logic [`AXI_DATA_WIDTH-1:0] data_t;
    typedef logic [`AXI_DATA_WIDTH/8-1:0] strb_t;

    typedef logic [`AXI_ID_WIDTH-1:0] axi_id_t;

    typedef logic [2:0] axi_size_t;  // log2 of bytes per beat
    typedef logic [3:0] axi_cache_t;  // bit 0 is bufferable

endpackage

// File: set_clr_reg_with_rst.sv
module set_clr_reg_with_rst #(
    parameter bit SET_OVER_CLR = 1'b0,
    parameter bit RST_VALUE = 1'b0
) (
    input  logic clk,
    input  logic rst,
    input  logic set,
    input  logic clr,
    output logic result
);

    always_ff @(posedge clk) begin
        if (rst) begin
            result <= RST_VALUE;
        end else if (SET_OVER_CLR) begin
            if (set)
                result <= 1'b1;
            else if (clr)
                result <= 1'b0;
        end else begin
            // clear has priority
            if (clr)
                result <= 1'b0;
            else if (set)
                result <= 1'b1;
        end
    end

endmodule

// File: axi_dcache_master.sv
`include "dcache_axi_params.svh"

module axi_dcache_master #(
    parameter int ID = 0
) (
    input  logic                       clk,
    input  logic                       rst,

    input  logic                       new_request,
    input  logic                       we,
    input  logic                       uncached,
    input  dcache_axi_pkg::addr_t      addr,
    input  dcache_axi_pkg::axi_size_t  size,
    input  dcache_axi_pkg::data_t      data_in,
    input  dcache_axi_pkg::strb_t      wstrb,
    output logic                       ready_out,
    output logic                       rvalid_out,
    output logic                       wvalid_out,
    output dcache_axi_pkg::data_t      data_out,

    // read address
    output logic                       arvalid,
    input  logic                       arready,
    output dcache_axi_pkg::addr_t      araddr,
    output dcache_axi_pkg::axi_size_t  arsize,
    output dcache_axi_pkg::axi_cache_t arcache,
    output dcache_axi_pkg::axi_id_t    arid,
    output logic [7:0]                 arlen,
    output logic [1:0]                 arburst,

    // write address
    output logic                       awvalid,
    input  logic                       awready,
    output dcache_axi_pkg::addr_t      awaddr,
    output dcache_axi_pkg::axi_size_t  awsize,
    output dcache_axi_pkg::axi_cache_t awcache,
    output dcache_axi_pkg::axi_id_t    awid,
    output logic [7:0]                 awlen,
    output logic [1:0]                 awburst,

    // write data
    output logic                       wvalid,
    input  logic                       wready,
    output dcache_axi_pkg::data_t      wdata,
    output dcache_axi_pkg::strb_t      wstrb_o,
    output logic                       wlast,

    // responses
    input  logic                       rvalid,
    output logic                       rready,
    input  dcache_axi_pkg::data_t      rdata,
    input  dcache_axi_pkg::axi_id_t    rid,
    input  logic                       bvalid,
    output logic                       bready,
    input  dcache_axi_pkg::axi_id_t    bid
);
    import dcache_axi_pkg::*;

    localparam axi_id_t MY_ID = axi_id_t'(ID);
    localparam int CNT_W = $clog2(`STUCK_LIMIT + 2);

    logic             ready;
    logic             rd_ours;
    logic             wr_ours;
    logic [CNT_W-1:0] not_ready_cnt;

    assign rd_ours = rvalid && (rid == MY_ID);
    assign wr_ours = bvalid && (bid == MY_ID);

    assign arid = MY_ID;
    assign awid = MY_ID;
    assign arlen = 8'd0;  // single beat
    assign awlen = 8'd0;
    assign arburst = 2'b01;
    assign awburst = 2'b01;
    assign wlast = wvalid;
    assign rready = 1'b1;  // responses always taken
    assign bready = 1'b1;

    always_ff @(posedge clk) begin
        if (new_request) begin
            araddr  <= addr;
            arsize  <= size;
            arcache <= uncached ? 4'b0000 : 4'b1111;
            awaddr  <= addr;
            awsize  <= size;
            awcache <= uncached ? 4'b0000 : 4'b0011;  // cached writes are bufferable
            wdata   <= data_in;
            wstrb_o <= wstrb;
        end
    end

    // busy from the request edge until our response is back
    set_clr_reg_with_rst #(
        .SET_OVER_CLR(1'b0),
        .RST_VALUE(1'b1)
    ) u_ready_reg (
        .clk,
        .rst,
        .set(rd_ours || wr_ours),
        .clr(new_request),
        .result(ready)
    );
    assign ready_out = ready;

    set_clr_reg_with_rst #(
        .SET_OVER_CLR(1'b1),
        .RST_VALUE(1'b0)
    ) u_arvalid_reg (
        .clk,
        .rst,
        .set(new_request && !we),
        .clr(arready),
        .result(arvalid)
    );

    set_clr_reg_with_rst #(
        .SET_OVER_CLR(1'b1),
        .RST_VALUE(1'b0)
    ) u_awvalid_reg (
        .clk,
        .rst,
        .set(new_request && we),
        .clr(awready),
        .result(awvalid)
    );

    set_clr_reg_with_rst #(
        .SET_OVER_CLR(1'b1),
        .RST_VALUE(1'b0)
    ) u_wvalid_reg (
        .clk,
        .rst,
        .set(new_request && we),
        .clr(wready),
        .result(wvalid)
    );

    always_ff @(posedge clk) begin
        if (rst) begin
            rvalid_out <= 1'b0;
            wvalid_out <= 1'b0;
        end else begin
            rvalid_out <= rd_ours;
            wvalid_out <= wr_ours;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_ours)
            data_out <= rdata;
    end

    always_ff @(posedge clk) begin
        if (rst || ready)
            not_ready_cnt <= '0;
        else
            not_ready_cnt <= not_ready_cnt + 1'b1;
    end

    // slave must answer in bounded time
    assert property (@(posedge clk) disable iff (rst)
        not_ready_cnt <= CNT_W'(`STUCK_LIMIT));

    // requester has to wait for ready
    assert property (@(posedge clk) disable iff (rst) new_request |-> ready);

endmodule

// File: axi_sram_slave.sv
`include "dcache_axi_params.svh"

module axi_sram_slave (
    input  logic                       clk,
    input  logic                       rst,

    // read address
    input  logic                       arvalid,
    output logic                       arready,
    input  dcache_axi_pkg::addr_t      araddr,
    input  dcache_axi_pkg::axi_size_t  arsize,
    input  dcache_axi_pkg::axi_cache_t arcache,
    input  dcache_axi_pkg::axi_id_t    arid,

    // write address
    input  logic                       awvalid,
    output logic                       awready,
    input  dcache_axi_pkg::addr_t      awaddr,
    input  dcache_axi_pkg::axi_size_t  awsize,
    input  dcache_axi_pkg::axi_cache_t awcache,
    input  dcache_axi_pkg::axi_id_t    awid,

    // write data
    input  logic                       wvalid,
    output logic                       wready,
    input  dcache_axi_pkg::data_t      wdata,
    input  dcache_axi_pkg::strb_t      wstrb,

    // responses
    output logic                       rvalid,
    input  logic                       rready,
    output dcache_axi_pkg::data_t      rdata,
    output dcache_axi_pkg::axi_id_t    rid,
    output logic                       bvalid,
    input  logic                       bready,
    output dcache_axi_pkg::axi_id_t    bid
);
    import dcache_axi_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int STRB_W = $bits(strb_t);
    localparam int LAT_W = $clog2(`MEM_LATENCY + 1);
    localparam logic [LAT_W-1:0] LAT = LAT_W'(`MEM_LATENCY);
    localparam axi_size_t MAX_SIZE = axi_size_t'($clog2(STRB_W));

    data_t mem [`MEM_WORDS];

    logic             ar_hs;
    logic             aw_hs;
    logic             w_hs;
    logic             rd_pending;
    logic             rd_fire;
    logic [LAT_W-1:0] rd_cnt;
    logic [IDX_W-1:0] rd_idx;
    logic             aw_done;
    logic             w_done;
    logic             wr_commit;
    logic             wr_pending;
    logic             wr_fire;
    logic [LAT_W-1:0] wr_cnt;
    logic [IDX_W-1:0] wr_idx;
    logic [1:0]       wr_offs;
    axi_size_t        wr_size;
    logic             wr_buf;
    data_t            wr_data;
    strb_t            wr_strb;

    // byte lanes a beat of this size may touch at this offset
    function automatic strb_t lane_mask(axi_size_t sz, logic [1:0] offs);
        case (sz)
            3'd0: lane_mask = strb_t'(4'b0001 << offs);
            3'd1: lane_mask = strb_t'(4'b0011 << {offs[1], 1'b0});
            default: lane_mask = '1;
        endcase
    endfunction

    // non-modifiable transactions must not be allocating
    function automatic logic cache_ok(axi_cache_t c);
        return c[1] || (c[3:2] == 2'b00);
    endfunction

    assign ar_hs = arvalid && arready;
    assign aw_hs = awvalid && awready;
    assign w_hs = wvalid && wready;

    assign arready = !rd_pending;
    assign awready = !aw_done && !wr_pending;
    assign wready = !w_done && !wr_pending;

    assign rd_fire = rd_pending && !rvalid && (rd_cnt == '0);
    assign wr_commit = aw_done && w_done;
    assign wr_fire = wr_pending && !bvalid && (wr_cnt == '0);

    always_ff @(posedge clk) begin
        if (rst) begin
            rd_pending <= 1'b0;
            rd_cnt <= '0;
            rvalid <= 1'b0;
        end else begin
            if (ar_hs) begin
                rd_pending <= 1'b1;
                rd_cnt <= LAT;
            end else if (rvalid && rready) begin
                rd_pending <= 1'b0;
            end else if (rd_pending && rd_cnt != '0) begin
                rd_cnt <= rd_cnt - 1'b1;
            end
            if (rd_fire)
                rvalid <= 1'b1;
            else if (rready)
                rvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (ar_hs) begin
            rd_idx <= araddr[IDX_W+1:2];
            rid <= arid;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            aw_done <= 1'b0;
            w_done <= 1'b0;
            wr_pending <= 1'b0;
            wr_cnt <= '0;
            bvalid <= 1'b0;
        end else begin
            if (aw_hs)
                aw_done <= 1'b1;
            else if (wr_commit)
                aw_done <= 1'b0;
            if (w_hs)
                w_done <= 1'b1;
            else if (wr_commit)
                w_done <= 1'b0;

            if (wr_commit) begin
                wr_pending <= 1'b1;
                wr_cnt <= wr_buf ? '0 : LAT - 1'b1;  // bufferable answers next cycle
            end else if (bvalid && bready) begin
                wr_pending <= 1'b0;
            end else if (wr_pending && wr_cnt != '0) begin
                wr_cnt <= wr_cnt - 1'b1;
            end

            if (wr_fire)
                bvalid <= 1'b1;
            else if (bready)
                bvalid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (aw_hs) begin
            wr_idx <= awaddr[IDX_W+1:2];
            wr_offs <= awaddr[1:0];
            wr_size <= awsize;
            wr_buf <= awcache[0];
            bid <= awid;
        end
        if (w_hs) begin
            wr_data <= wdata;
            wr_strb <= wstrb;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_commit) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (wr_strb[i])
                    mem[wr_idx][8*i +: 8] <= wr_data[8*i +: 8];
            end
        end
        if (rd_fire)
            rdata <= mem[rd_idx];
    end

    // strobes from the data beat agree with size and offset from the address beat
    assert property (@(posedge clk) disable iff (rst)
        wr_commit |-> ((wr_strb & ~lane_mask(wr_size, wr_offs)) == '0));

    // responses are single-cycle only because the master never stalls them
    assert property (@(posedge clk) disable iff (rst) rvalid |-> rready);

    assert property (@(posedge clk) disable iff (rst)
        (!arvalid || (arsize <= MAX_SIZE && cache_ok(arcache)))
        && (!awvalid || (awsize <= MAX_SIZE && cache_ok(awcache))));

endmodule

// File: dcache_axi_top.sv
module dcache_axi_top (
    input  logic                      clk,
    input  logic                      rst,
    input  logic                      new_request,
    input  logic                      we,
    input  logic                      uncached,
    input  dcache_axi_pkg::addr_t     addr,
    input  dcache_axi_pkg::axi_size_t size,
    input  dcache_axi_pkg::data_t     data_in,
    input  dcache_axi_pkg::strb_t     wstrb,
    output logic                      ready_out,
    output logic                      rvalid_out,
    output logic                      wvalid_out,
    output dcache_axi_pkg::data_t     data_out
);
    import dcache_axi_pkg::*;

    logic       arvalid;
    logic       arready;
    addr_t      araddr;
    axi_size_t  arsize;
    axi_cache_t arcache;
    axi_id_t    arid;
    logic       awvalid;
    logic       awready;
    addr_t      awaddr;
    axi_size_t  awsize;
    axi_cache_t awcache;
    axi_id_t    awid;
    logic       wvalid;
    logic       wready;
    data_t      wdata;
    strb_t      wstrb_o;
    logic       rvalid;
    logic       rready;
    data_t      rdata;
    axi_id_t    rid;
    logic       bvalid;
    logic       bready;
    axi_id_t    bid;

    // single beat only, so len, burst and wlast stay open
    axi_dcache_master #(
        .ID(5)
    ) u_master (
        .arlen(),
        .arburst(),
        .awlen(),
        .awburst(),
        .wlast(),
        .*
    );

    axi_sram_slave u_slave (
        .wstrb(wstrb_o),  // bus strobes, not the request-side ones
        .*
    );

endmodule

// File: dcache_axi_checker.sv
`include "dcache_axi_params.svh"

module dcache_axi_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  new_request,
    input  logic                  we,
    input  logic                  uncached,
    input  dcache_axi_pkg::data_t exp_data,
    input  logic                  ready_out,
    input  logic                  rvalid_out,
    input  logic                  wvalid_out,
    input  dcache_axi_pkg::data_t data_out,
    input  logic                  test_end,
    input  int                    test_id,
    input  logic                  all_done,
    output int                    error_count
);
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_axi_pkg::*;

    localparam int READ_LAT = `MEM_LATENCY + 3;
    localparam int UNCACHED_WR_LAT = `MEM_LATENCY + 3;
    localparam int CACHED_WR_LAT = 4;  // bufferable write is answered early

    int    cycle;
    int    req_cycle;
    int    req_count;
    int    resp_count;
    int    check_count;
    int    test_base;
    int    lat;
    int    exp_lat;
    logic  busy;
    logic  req_we;
    logic  req_unc;
    data_t req_data;

    task automatic note_mismatch(input string sig, input logic [31:0] got,
                                 input logic [31:0] expected);
        error_count++;
        $display("Mismatch at %0d ns: %s is %0h, expected %0h", $time, sig, got, expected);
    endtask

    task automatic note_failure(input string what);
        error_count++;
        $display("Error at %0d ns: %s", $time, what);
    endtask

    function automatic string test_name(int id);
        case (id)
            1: return "reset state";
            2: return "full-word round trip";
            3: return "partial writes";
            4: return "read latency";
            5: return "cached and uncached writes";
            6: return "random mixed traffic";
            default: return "unknown";
        endcase
    endfunction

    always @(posedge clk) begin
        if (rst) begin
            cycle = 0;
            busy = 1'b0;
            error_count = 0;
            req_count = 0;
            resp_count = 0;
            check_count = 0;
            test_base = 0;
        end else begin
            cycle++;
            if (rvalid_out === 1'b1 || wvalid_out === 1'b1) begin
                if (!busy) begin
                    note_failure("response pulse with no request outstanding");
                end else begin
                    busy = 1'b0;
                    resp_count++;
                    lat = cycle - req_cycle - 1;  // pulse was registered one edge ago
                    exp_lat = !req_we ? READ_LAT : (req_unc ? UNCACHED_WR_LAT : CACHED_WR_LAT);
                    check_count++;
                    if (lat != exp_lat)
                        note_mismatch("response latency", lat, exp_lat);
                    if (req_we && (wvalid_out !== 1'b1 || rvalid_out !== 1'b0))
                        note_failure("write request answered without a lone wvalid_out");
                    if (!req_we && (rvalid_out !== 1'b1 || wvalid_out !== 1'b0))
                        note_failure("read request answered without a lone rvalid_out");
                    if (!req_we) begin
                        check_count++;
                        if (data_out !== req_data)
                            note_mismatch("data_out", data_out, req_data);
                    end
                    if (ready_out !== 1'b1)
                        note_mismatch("ready_out", 32'(ready_out), 32'd1);
                end
            end else if (busy) begin
                if (ready_out !== 1'b0)
                    note_mismatch("ready_out", 32'(ready_out), 32'd0);
            end else if (ready_out !== 1'b1) begin
                note_mismatch("ready_out", 32'(ready_out), 32'd1);  // idle must be ready
            end

            if (new_request === 1'b1) begin
                if (busy)
                    note_failure("new request issued while one is outstanding");
                busy = 1'b1;
                req_cycle = cycle;
                req_we = we;
                req_unc = uncached;
                req_data = exp_data;
                req_count++;
            end

            if (test_end === 1'b1) begin
                $display("test %0d %s: %s, %0d errors", test_id, test_name(test_id),
                         (error_count == test_base) ? "ok" : "FAILED", error_count - test_base);
                test_base = error_count;
            end

            if (all_done === 1'b1) begin
                if (busy)
                    note_failure("last request never got a response");
                if (req_count != resp_count)
                    note_failure("request and response counts differ");
                $display("checks %0d, errors %0d, requests %0d, responses %0d",
                         check_count, error_count, req_count, resp_count);
            end
        end
    end

endmodule

// File: tb_dcache_axi.sv
`include "dcache_axi_params.svh"

module tb_dcache_axi;
    timeunit 1ns;
    timeprecision 100ps;
    import dcache_axi_pkg::*;

    localparam int IDX_W = $clog2(`MEM_WORDS);
    localparam int N_REQUESTS = 2 * 16 + 2 * 16 + 4 + 16 + 200;
    localparam int TIMEOUT_CYCLES = N_REQUESTS * (`MEM_LATENCY + 4) + 200;

    logic      clk;
    logic      rst;
    logic      new_request;
    logic      we;
    logic      uncached;
    addr_t     addr;
    axi_size_t size;
    data_t     data_in;
    strb_t     wstrb;
    logic      ready_out;
    logic      rvalid_out;
    logic      wvalid_out;
    data_t     data_out;
    data_t     exp_data;
    logic      test_end;
    int        test_id;
    logic      all_done;
    int        error_count;
    int        timeout_cnt;
    int        seed;
    data_t     ref_mem [`MEM_WORDS];

    dcache_axi_top u_dut (
        .clk,
        .rst,
        .new_request,
        .we,
        .uncached,
        .addr,
        .size,
        .data_in,
        .wstrb,
        .ready_out,
        .rvalid_out,
        .wvalid_out,
        .data_out
    );

    dcache_axi_checker u_chk (.*);

    always #10 clk = ~clk;

    // spread the 16 test words over the whole array
    function automatic addr_t word_addr(int k);
        return addr_t'(k * 17 * 4);
    endfunction

    function automatic void ref_write(addr_t a, data_t d, strb_t s);
        data_t w;
        w = ref_mem[a[IDX_W+1:2]];
        for (int i = 0; i < 4; i++) begin
            if (s[i])
                w[8*i +: 8] = d[8*i +: 8];
        end
        ref_mem[a[IDX_W+1:2]] = w;
    endfunction

    function automatic data_t ref_read(addr_t a);
        return ref_mem[a[IDX_W+1:2]];
    endfunction

    task automatic issue(input logic is_we, input logic is_unc, input addr_t a,
                         input axi_size_t sz, input data_t d, input strb_t s);
        @(negedge clk);
        new_request = 1'b0;
        while (ready_out !== 1'b1)
            @(negedge clk);
        we = is_we;
        uncached = is_unc;
        addr = a;
        size = sz;
        data_in = d;
        wstrb = s;
        exp_data = is_we ? d : ref_read(a);
        if (is_we)
            ref_write(a, d, s);
        new_request = 1'b1;
    endtask

    task automatic write_word(input addr_t a, input logic unc, input data_t d);
        issue(1'b1, unc, a, 3'd2, d, 4'b1111);
    endtask

    task automatic read_word(input addr_t a, input logic unc);
        issue(1'b0, unc, a, 3'd2, '0, '0);
    endtask

    // narrow write, strobes kept inside the lanes of the chosen size
    task automatic write_random_lanes(input addr_t base, input logic unc);
        logic [31:0] r;
        logic [1:0]  offs;
        axi_size_t   sz;
        strb_t       s;
        r = $random(seed);
        case (r[1:0])
            2'd0: begin
                sz = 3'd0;
                offs = r[3:2];
                s = strb_t'(4'b0001 << offs);
            end
            2'd1: begin
                sz = 3'd1;
                offs = {r[2], 1'b0};
                s = strb_t'(4'b0011 << offs);
            end
            default: begin
                sz = 3'd2;
                offs = 2'd0;
                s = 4'b1111;
            end
        endcase
        issue(1'b1, unc, base | addr_t'(offs), sz, $random(seed), s);
    endtask

    task automatic end_test(input int id);
        @(negedge clk);
        new_request = 1'b0;
        while (ready_out !== 1'b1)
            @(negedge clk);
        test_id = id;
        test_end = 1'b1;
        @(negedge clk);
        test_end = 1'b0;
    endtask

    initial begin
        timeout_cnt = 0;
        while (timeout_cnt < TIMEOUT_CYCLES) begin
            @(posedge clk);
            timeout_cnt++;
        end
        $display("timeout after %0d cycles, the DUT stopped answering", TIMEOUT_CYCLES);
        $display("Simulation failed");
        $finish;
    end

    initial begin
        data_t       d;
        logic [31:0] r;
        addr_t       a;
        clk = 1'b0;
        rst = 1'b1;
        new_request = 1'b0;
        we = 1'b0;
        uncached = 1'b0;
        addr = '0;
        size = '0;
        data_in = '0;
        wstrb = '0;
        exp_data = '0;
        test_end = 1'b0;
        test_id = 0;
        all_done = 1'b0;
        seed = 32'hcb06_3d99;
        repeat (4) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;

        repeat (5) @(negedge clk);  // idle, ready high and no pulses
        end_test(1);

        for (int k = 0; k < 16; k++)
            write_word(word_addr(k), k[0], $random(seed));
        for (int k = 0; k < 16; k++)
            read_word(word_addr(k), k[1]);
        end_test(2);

        for (int k = 0; k < 16; k++)
            write_random_lanes(word_addr(k), k[1]);
        for (int k = 0; k < 16; k++)
            read_word(word_addr(k), k[0]);
        end_test(3);

        for (int i = 0; i < 4; i++)
            read_word(word_addr(4 * i + 1), i[0]);
        end_test(4);

        // same data through a bufferable and an uncached write
        for (int k = 0; k < 4; k++) begin
            d = $random(seed);
            write_word(word_addr(k), 1'b0, d);
            write_word(word_addr(k + 8), 1'b1, d);
        end
        for (int k = 0; k < 4; k++) begin
            read_word(word_addr(k), 1'b0);
            read_word(word_addr(k + 8), 1'b1);
        end
        end_test(5);

        for (int n = 0; n < 200; n++) begin
            r = $random(seed);
            a = word_addr(int'(r[3:0])) | (addr_t'($random(seed)) & 32'hffff_fc00);
            if (r[4])
                write_random_lanes(a, r[5]);
            else
                read_word(a, r[5]);
        end
        end_test(6);

        @(negedge clk);
        all_done = 1'b1;
        @(negedge clk);
        all_done = 1'b0;
        @(negedge clk);
        if (error_count == 0)
            $display("Simulation completed successfully");
        else
            $display("Simulation failed");
        $finish;
    end

endmodule

// File: sources.f
+incdir+.
dcache_axi_pkg.sv
set_clr_reg_with_rst.sv
axi_dcache_master.sv
axi_sram_slave.sv
dcache_axi_top.sv
dcache_axi_checker.sv
tb_dcache_axi.sv

// File: run_sim.sh
#!/bin/sh
# build the testbench with Verilator, run it and look for the pass line in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module tb_dcache_axi \
    -f sources.f -o sim_dcache_axi \
    && ./obj_dir/sim_dcache_axi > sim.log 2>&1 ; cat sim.log 2>/dev/null

grep -q "^Simulation completed successfully$" sim.log \
    && echo "PASS" \
    || { echo "FAIL"; exit 1; }
